// ==== rtl/sparcPkg.sv ====
package sparcPkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int NumRegs      = 2 ** RegAddrWidth;
    localparam int Op3Width     = 6;
    localparam int AluOpWidth   = 4;
    localparam int CcWidth      = 4;
    localparam int ShamtWidth   = $clog2(DataWidth);

    // Instruction word field positions
    localparam int OpLsb       = 30;
    localparam int RdLsb       = 25;
    localparam int Op2Lsb      = 22;
    localparam int Op3Lsb      = 19;
    localparam int Rs1Lsb      = 14;
    localparam int IBit        = 13;
    localparam int Rs2Lsb      = 0;
    localparam int Simm13Width = 13;
    localparam int Imm22Width  = 22;
    localparam int SethiShift  = 10;
    localparam int Op3CcBit    = 4;    // Set on the cc variants

    localparam logic [1:0] OpSethi  = 2'b00;   // Format 2, qualified by op2
    localparam logic [1:0] OpArith  = 2'b10;
    localparam logic [2:0] Op2Sethi = 3'b100;

    // op3 with the cc bit cleared
    localparam logic [Op3Width-1:0] Op3Add  = 6'h00;
    localparam logic [Op3Width-1:0] Op3And  = 6'h01;
    localparam logic [Op3Width-1:0] Op3Or   = 6'h02;
    localparam logic [Op3Width-1:0] Op3Xor  = 6'h03;
    localparam logic [Op3Width-1:0] Op3Sub  = 6'h04;
    localparam logic [Op3Width-1:0] Op3Andn = 6'h05;
    localparam logic [Op3Width-1:0] Op3Orn  = 6'h06;
    localparam logic [Op3Width-1:0] Op3Xnor = 6'h07;
    localparam logic [Op3Width-1:0] Op3Addx = 6'h08;
    localparam logic [Op3Width-1:0] Op3Subx = 6'h0C;
    localparam logic [Op3Width-1:0] Op3Sll  = 6'h25;
    localparam logic [Op3Width-1:0] Op3Srl  = 6'h26;
    localparam logic [Op3Width-1:0] Op3Sra  = 6'h27;

    // Condition code bits, N Z V C from the top
    localparam int FlagN = 3;
    localparam int FlagZ = 2;
    localparam int FlagV = 1;
    localparam int FlagC = 0;

    localparam logic [AluOpWidth-1:0] AluAdd   = 4'd0;
    localparam logic [AluOpWidth-1:0] AluAddx  = 4'd1;
    localparam logic [AluOpWidth-1:0] AluSub   = 4'd2;
    localparam logic [AluOpWidth-1:0] AluSubx  = 4'd3;
    localparam logic [AluOpWidth-1:0] AluAnd   = 4'd4;
    localparam logic [AluOpWidth-1:0] AluOr    = 4'd5;
    localparam logic [AluOpWidth-1:0] AluXor   = 4'd6;
    localparam logic [AluOpWidth-1:0] AluAndn  = 4'd7;
    localparam logic [AluOpWidth-1:0] AluOrn   = 4'd8;
    localparam logic [AluOpWidth-1:0] AluXnor  = 4'd9;
    localparam logic [AluOpWidth-1:0] AluSll   = 4'd10;
    localparam logic [AluOpWidth-1:0] AluSrl   = 4'd11;
    localparam logic [AluOpWidth-1:0] AluSra   = 4'd12;
    localparam logic [AluOpWidth-1:0] AluPassB = 4'd13;

    // Retire queue, also the issue credits held by the source after reset
    localparam int RetireDepth    = 4;
    localparam int RetirePtrWidth = $clog2(RetireDepth);
    localparam int CreditWidth    = 16;   // Consumer credits may pile up while idle

endpackage

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
    import sparcPkg::*;
(
    input  logic [DataWidth-1:0]  instr,
    output logic [AluOpWidth-1:0] aluOp,
    output logic                  writeEn,
    output logic                  ccEn,
    output logic                  useImm,
    output logic [DataWidth-1:0]  imm
);

    logic [1:0]          op;
    logic [2:0]          op2;
    logic [Op3Width-1:0] op3;
    logic [Op3Width-1:0] op3Base;
    logic                known;
    logic                ccSel;

    assign op      = instr[OpLsb +: 2];
    assign op2     = instr[Op2Lsb +: 3];
    assign op3     = instr[Op3Lsb +: Op3Width];
    assign op3Base = op3 & ~(Op3Width'(1) << Op3CcBit);

    always_comb
    begin
        aluOp  = AluAdd;
        known  = 1'b1;
        ccSel  = 1'b0;
        useImm = instr[IBit];
        imm    = {{(DataWidth - Simm13Width){instr[Simm13Width-1]}},
                  instr[Simm13Width-1:0]};
        if (op == OpSethi && op2 == Op2Sethi)
        begin
            // Also covers nop, which targets %g0
            aluOp  = AluPassB;
            useImm = 1'b1;
            imm    = DataWidth'(instr[Imm22Width-1:0]) << SethiShift;
        end
        else if (op == OpArith)
        begin
            // 11xxxx holds save, jmpl and friends, none of them kept
            known = ~(op3[Op3Width-1] & op3[Op3CcBit]);
            ccSel = op3[Op3CcBit];
            case (op3Base)
                Op3Add:  aluOp = AluAdd;
                Op3Addx: aluOp = AluAddx;
                Op3Sub:  aluOp = AluSub;
                Op3Subx: aluOp = AluSubx;
                Op3And:  aluOp = AluAnd;
                Op3Andn: aluOp = AluAndn;
                Op3Or:   aluOp = AluOr;
                Op3Orn:  aluOp = AluOrn;
                Op3Xor:  aluOp = AluXor;
                Op3Xnor: aluOp = AluXnor;
                Op3Sll:  aluOp = AluSll;
                Op3Srl:  aluOp = AluSrl;
                Op3Sra:  aluOp = AluSra;
                default: known = 1'b0;
            endcase
        end
        else
        begin
            known = 1'b0;   // Call, branches, memory ops
        end
    end

    // No write for %g0 so it never shows up as a forwarding source
    assign writeEn = known && (instr[RdLsb +: RegAddrWidth] != '0);
    assign ccEn    = known && ccSel;

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
    import sparcPkg::*;
(
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic [RegAddrWidth-1:0] rdAddrA,
    input  logic [RegAddrWidth-1:0] rdAddrB,
    output logic [DataWidth-1:0]    rdDataA,
    output logic [DataWidth-1:0]    rdDataB,
    input  logic                    wrEn,
    input  logic [RegAddrWidth-1:0] wrAddr,
    input  logic [DataWidth-1:0]    wrData
);

    logic [DataWidth-1:0] regs [NumRegs];

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < NumRegs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && wrAddr != '0)   // %g0 stays zero
        begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage
    import sparcPkg::*;
(
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    inValid,
    input  logic [DataWidth-1:0]    inInstr,
    output logic [RegAddrWidth-1:0] rfAddrA,
    output logic [RegAddrWidth-1:0] rfAddrB,
    input  logic [DataWidth-1:0]    rfDataA,
    input  logic [DataWidth-1:0]    rfDataB,
    input  logic                    exWriteEn,
    input  logic [RegAddrWidth-1:0] exRd,
    input  logic [DataWidth-1:0]    exResult,
    input  logic                    wbWriteEn,
    input  logic [RegAddrWidth-1:0] wbRd,
    input  logic [DataWidth-1:0]    wbResult,
    output logic                    dxValid,
    output logic [AluOpWidth-1:0]   dxAluOp,
    output logic [DataWidth-1:0]    dxOpA,
    output logic [DataWidth-1:0]    dxOpB,
    output logic [RegAddrWidth-1:0] dxRd,
    output logic                    dxWriteEn,
    output logic                    dxCcEn
);

    logic                  idValid;
    logic [DataWidth-1:0]  idInstr;
    logic [AluOpWidth-1:0] aluOp;
    logic                  writeEn;
    logic                  ccEn;
    logic                  useImm;
    logic [DataWidth-1:0]  imm;
    logic [DataWidth-1:0]  opA;
    logic [DataWidth-1:0]  opB;

    instrDecoder u_instrDecoder (
        .instr   (idInstr),
        .aluOp   (aluOp),
        .writeEn (writeEn),
        .ccEn    (ccEn),
        .useImm  (useImm),
        .imm     (imm)
    );

    assign rfAddrA = idInstr[Rs1Lsb +: RegAddrWidth];
    assign rfAddrB = idInstr[Rs2Lsb +: RegAddrWidth];

    // Youngest producer wins
    function automatic logic [DataWidth-1:0] forwardOperand(
        input logic [RegAddrWidth-1:0] addr,
        input logic [DataWidth-1:0]    rfData
    );
        if (addr == '0)
            return '0;
        else if (exWriteEn && exRd == addr)
            return exResult;
        else if (wbWriteEn && wbRd == addr)
            return wbResult;
        else
            return rfData;
    endfunction

    always_comb
    begin
        opA = forwardOperand(rfAddrA, rfDataA);
        opB = useImm ? imm : forwardOperand(rfAddrB, rfDataB);
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            idValid   <= 1'b0;
            dxValid   <= 1'b0;
            dxWriteEn <= 1'b0;
            dxCcEn    <= 1'b0;
        end
        else
        begin
            idValid   <= inValid;
            dxValid   <= idValid;
            dxWriteEn <= idValid & writeEn;   // Bubbles never write
            dxCcEn    <= idValid & ccEn;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (inValid)
        begin
            idInstr <= inInstr;
        end
        dxAluOp <= aluOp;
        dxOpA   <= opA;
        dxOpB   <= opB;
        dxRd    <= idInstr[RdLsb +: RegAddrWidth];
    end

endmodule

// ==== rtl/executeStage.sv ====
`timescale 1ns/1ps

module executeStage
    import sparcPkg::*;
(
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    dxValid,
    input  logic [AluOpWidth-1:0]   dxAluOp,
    input  logic [DataWidth-1:0]    dxOpA,
    input  logic [DataWidth-1:0]    dxOpB,
    input  logic [RegAddrWidth-1:0] dxRd,
    input  logic                    dxWriteEn,
    input  logic                    dxCcEn,
    output logic                    exWriteEn,
    output logic [RegAddrWidth-1:0] exRd,
    output logic [DataWidth-1:0]    exResult,
    output logic                    wbValid,
    output logic [RegAddrWidth-1:0] wbRd,
    output logic                    wbWriteEn,
    output logic [DataWidth-1:0]    wbResult,
    output logic [CcWidth-1:0]      wbCc
);

    logic [DataWidth-1:0] result;
    logic [DataWidth:0]   sum;
    logic                 carryIn;
    logic                 ovf;
    logic                 carry;
    logic [CcWidth-1:0]   flags;
    logic [CcWidth-1:0]   psr;   // icc field of the status register

    assign carryIn = (dxAluOp == AluAddx || dxAluOp == AluSubx) ? psr[FlagC] : 1'b0;

    always_comb
    begin
        sum    = '0;
        result = '0;
        ovf    = 1'b0;
        carry  = 1'b0;
        case (dxAluOp)
            AluAdd, AluAddx:
            begin
                sum    = {1'b0, dxOpA} + {1'b0, dxOpB} + {{DataWidth{1'b0}}, carryIn};
                result = sum[DataWidth-1:0];
                carry  = sum[DataWidth];
                ovf    = (dxOpA[DataWidth-1] == dxOpB[DataWidth-1])
                         && (result[DataWidth-1] != dxOpA[DataWidth-1]);
            end
            AluSub, AluSubx:
            begin
                sum    = {1'b0, dxOpA} - {1'b0, dxOpB} - {{DataWidth{1'b0}}, carryIn};
                result = sum[DataWidth-1:0];
                carry  = sum[DataWidth];   // Borrow
                ovf    = (dxOpA[DataWidth-1] != dxOpB[DataWidth-1])
                         && (result[DataWidth-1] != dxOpA[DataWidth-1]);
            end
            AluAnd:   result = dxOpA & dxOpB;
            AluAndn:  result = dxOpA & ~dxOpB;
            AluOr:    result = dxOpA | dxOpB;
            AluOrn:   result = dxOpA | ~dxOpB;
            AluXor:   result = dxOpA ^ dxOpB;
            AluXnor:  result = ~(dxOpA ^ dxOpB);
            AluSll:   result = dxOpA << dxOpB[ShamtWidth-1:0];
            AluSrl:   result = dxOpA >> dxOpB[ShamtWidth-1:0];
            AluSra:   result = $signed(dxOpA) >>> dxOpB[ShamtWidth-1:0];
            AluPassB: result = dxOpB;   // sethi
            default:  result = '0;
        endcase
    end

    // Logic ops leave V and C clear
    always_comb
    begin
        flags        = '0;
        flags[FlagN] = result[DataWidth-1];
        flags[FlagZ] = (result == '0);
        flags[FlagV] = ovf;
        flags[FlagC] = carry;
    end

    assign exWriteEn = dxWriteEn;
    assign exRd      = dxRd;
    assign exResult  = result;

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            psr       <= '0;
            wbValid   <= 1'b0;
            wbWriteEn <= 1'b0;
        end
        else
        begin
            if (dxCcEn)
            begin
                psr <= flags;
            end
            wbValid   <= dxValid;
            wbWriteEn <= dxWriteEn;
        end
    end

    always_ff @(posedge Clk)
    begin
        wbRd     <= dxRd;
        wbResult <= result;
        wbCc     <= dxCcEn ? flags : psr;   // Status as seen after this instruction
    end

endmodule

// ==== rtl/retireBuffer.sv ====
`timescale 1ns/1ps

module retireBuffer
    import sparcPkg::*;
(
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    wbValid,
    input  logic [RegAddrWidth-1:0] wbRd,
    input  logic                    wbWriteEn,
    input  logic [DataWidth-1:0]    wbResult,
    input  logic [CcWidth-1:0]      wbCc,
    input  logic                    retCredit,
    output logic                    retValid,
    output logic [RegAddrWidth-1:0] retRd,
    output logic [DataWidth-1:0]    retData,
    output logic [CcWidth-1:0]      retCc,
    output logic                    inCredit
);

    logic [RegAddrWidth-1:0]   rdMem   [RetireDepth];
    logic [DataWidth-1:0]      dataMem [RetireDepth];
    logic [CcWidth-1:0]        ccMem   [RetireDepth];
    logic [RetirePtrWidth-1:0] wrPtr;
    logic [RetirePtrWidth-1:0] rdPtr;
    logic [RetirePtrWidth:0]   count;
    logic [CreditWidth-1:0]    creditCnt;
    logic                      push;
    logic                      pop;

    assign push = wbValid;
    assign pop  = (count != '0) && (creditCnt != '0);

    // No-write entries retire as rd 0, data 0
    always_ff @(posedge Clk)
    begin
        if (push)
        begin
            rdMem[wrPtr]   <= wbWriteEn ? wbRd : '0;
            dataMem[wrPtr] <= wbWriteEn ? wbResult : '0;
            ccMem[wrPtr]   <= wbCc;
        end
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            creditCnt <= '0;
            inCredit  <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            count     <= count + (RetirePtrWidth + 1)'(push) - (RetirePtrWidth + 1)'(pop);
            creditCnt <= creditCnt + CreditWidth'(retCredit) - CreditWidth'(pop);
            inCredit  <= pop;   // Slot freed, hand the credit back to the source
        end
    end

    assign retValid = pop;
    assign retRd    = rdMem[rdPtr];
    assign retData  = dataMem[rdPtr];
    assign retCc    = ccMem[rdPtr];

endmodule

// ==== rtl/sparcCore.sv ====
`timescale 1ns/1ps

module sparcCore
    import sparcPkg::*;
(
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    inValid,
    input  logic [DataWidth-1:0]    inInstr,
    output logic                    inCredit,
    input  logic                    retCredit,
    output logic                    retValid,
    output logic [RegAddrWidth-1:0] retRd,
    output logic [DataWidth-1:0]    retData,
    output logic [CcWidth-1:0]      retCc
);

    logic [RegAddrWidth-1:0] rfAddrA;
    logic [RegAddrWidth-1:0] rfAddrB;
    logic [DataWidth-1:0]    rfDataA;
    logic [DataWidth-1:0]    rfDataB;

    logic                    dxValid;
    logic [AluOpWidth-1:0]   dxAluOp;
    logic [DataWidth-1:0]    dxOpA;
    logic [DataWidth-1:0]    dxOpB;
    logic [RegAddrWidth-1:0] dxRd;
    logic                    dxWriteEn;
    logic                    dxCcEn;

    logic                    exWriteEn;
    logic [RegAddrWidth-1:0] exRd;
    logic [DataWidth-1:0]    exResult;

    logic                    wbValid;
    logic [RegAddrWidth-1:0] wbRd;
    logic                    wbWriteEn;
    logic [DataWidth-1:0]    wbResult;
    logic [CcWidth-1:0]      wbCc;

    decodeStage u_decodeStage (
        .Clk       (Clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inInstr   (inInstr),
        .rfAddrA   (rfAddrA),
        .rfAddrB   (rfAddrB),
        .rfDataA   (rfDataA),
        .rfDataB   (rfDataB),
        .exWriteEn (exWriteEn),
        .exRd      (exRd),
        .exResult  (exResult),
        .wbWriteEn (wbWriteEn),
        .wbRd      (wbRd),
        .wbResult  (wbResult),
        .dxValid   (dxValid),
        .dxAluOp   (dxAluOp),
        .dxOpA     (dxOpA),
        .dxOpB     (dxOpB),
        .dxRd      (dxRd),
        .dxWriteEn (dxWriteEn),
        .dxCcEn    (dxCcEn)
    );

    // Written from the writeback register, one edge after the result lands there
    registerFile u_registerFile (
        .Clk     (Clk),
        .arstN   (arstN),
        .rdAddrA (rfAddrA),
        .rdAddrB (rfAddrB),
        .rdDataA (rfDataA),
        .rdDataB (rfDataB),
        .wrEn    (wbWriteEn),
        .wrAddr  (wbRd),
        .wrData  (wbResult)
    );

    executeStage u_executeStage (
        .Clk       (Clk),
        .arstN     (arstN),
        .dxValid   (dxValid),
        .dxAluOp   (dxAluOp),
        .dxOpA     (dxOpA),
        .dxOpB     (dxOpB),
        .dxRd      (dxRd),
        .dxWriteEn (dxWriteEn),
        .dxCcEn    (dxCcEn),
        .exWriteEn (exWriteEn),
        .exRd      (exRd),
        .exResult  (exResult),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbWriteEn (wbWriteEn),
        .wbResult  (wbResult),
        .wbCc      (wbCc)
    );

    retireBuffer u_retireBuffer (
        .Clk       (Clk),
        .arstN     (arstN),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbWriteEn (wbWriteEn),
        .wbResult  (wbResult),
        .wbCc      (wbCc),
        .retCredit (retCredit),
        .retValid  (retValid),
        .retRd     (retRd),
        .retData   (retData),
        .retCc     (retCc),
        .inCredit  (inCredit)
    );

endmodule

// ==== tests/sparcCore_asserts.sv ====
`timescale 1ns/1ps

module sparcCore_asserts
    import sparcPkg::*;
(
    input logic                    Clk,
    input logic                    arstN,
    input logic                    retCredit,
    input logic                    retValid,
    input logic                    inCredit,
    input logic                    wbValid,
    input logic [RetirePtrWidth:0] count
);

    int grantTotal;   // Consumer credits handed to the core
    int popTotal;
    int creditTotal;

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            grantTotal  <= 0;
            popTotal    <= 0;
            creditTotal <= 0;
        end
        else
        begin
            grantTotal  <= grantTotal + int'(retCredit);
            popTotal    <= popTotal + int'(retValid);
            creditTotal <= creditTotal + int'(inCredit);
        end
    end

    resetQuiet: assert property (@(posedge Clk) !arstN |-> (!retValid && !inCredit))
        else $error("retValid or inCredit high during reset");

    popNeedsCredit: assert property (@(posedge Clk) disable iff (!arstN)
        retValid |-> (grantTotal > popTotal))
        else $error("retire without an unspent consumer credit");

    noPushWhenFull: assert property (@(posedge Clk) disable iff (!arstN)
        wbValid |-> (count < (RetirePtrWidth + 1)'(RetireDepth)))
        else $error("push into full retire queue");

    creditsBounded: assert property (@(posedge Clk) disable iff (!arstN)
        (creditTotal + int'(inCredit)) <= popTotal)
        else $error("more issue credits than pops");

endmodule

bind sparcCore sparcCore_asserts u_sparcCoreAsserts (
    .Clk       (Clk),
    .arstN     (arstN),
    .retCredit (retCredit),
    .retValid  (retValid),
    .inCredit  (inCredit),
    .wbValid   (wbValid),
    .count     (u_retireBuffer.count)
);

// ==== tests/sparcCoreTb.sv ====
`timescale 1ns/1ps

module sparcCoreTb
    import sparcPkg::*;
();

    localparam int MaxVectors = 64;
    localparam int LfsrSeed   = 16;

    logic                    Clk;
    logic                    arstN;
    logic                    inValid;
    logic [DataWidth-1:0]    inInstr;
    logic                    inCredit;
    logic                    retCredit;
    logic                    retValid;
    logic [RegAddrWidth-1:0] retRd;
    logic [DataWidth-1:0]    retData;
    logic [CcWidth-1:0]      retCc;

    // Word 0 holds the vector count, then four words per vector
    logic [31:0] vecMem [0:4*MaxVectors];

    int          numVectors;
    int          issued;
    int          retired;
    int          issueCredits;
    int          creditPulses;
    int          cycles;
    int          cycleLimit;
    int          valueErrors;
    int          otherErrors;
    logic [15:0] lfsr;

    sparcCore u_sparcCore (
        .Clk       (Clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inInstr   (inInstr),
        .inCredit  (inCredit),
        .retCredit (retCredit),
        .retValid  (retValid),
        .retRd     (retRd),
        .retData   (retData),
        .retCc     (retCc)
    );

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] stepLfsr(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hB400;
        else
            return state >> 1;
    endfunction

    task automatic compareRetired();
        int idx;
        idx = retired;
        if (idx >= numVectors)
        begin
            $display("Unexpected extra result retired after %0d vectors", numVectors);
            otherErrors++;
            return;
        end
        if (retRd !== vecMem[4*idx + 2][RegAddrWidth-1:0])
        begin
            $display("[ERROR] vector %0d rd: expected %0d, got %0d",
                     idx, vecMem[4*idx + 2][RegAddrWidth-1:0], retRd);
            valueErrors++;
        end
        if (retData !== vecMem[4*idx + 3])
        begin
            $display("[ERROR] vector %0d data: expected %h, got %h",
                     idx, vecMem[4*idx + 3], retData);
            valueErrors++;
        end
        if (retCc !== vecMem[4*idx + 4][CcWidth-1:0])
        begin
            $display("[ERROR] vector %0d cc: expected %h, got %h",
                     idx, vecMem[4*idx + 4][CcWidth-1:0], retCc);
            valueErrors++;
        end
        retired++;
    endtask

    initial
    begin
        arstN        = 1'b1;
        inValid      = 1'b0;
        inInstr      = '0;
        retCredit    = 1'b0;
        issued       = 0;
        retired      = 0;
        creditPulses = 0;
        cycles       = 0;
        valueErrors  = 0;
        otherErrors  = 0;
        lfsr         = 16'(LfsrSeed);
        issueCredits = RetireDepth;

        $readmemh("tests/sparcCore_vectors.txt", vecMem);
        numVectors = int'(vecMem[0]);
        if (numVectors <= 0 || numVectors > MaxVectors)
        begin
            $display("Vector file gives no usable vector count (%0d)", numVectors);
            otherErrors++;
            numVectors = 0;
        end
        cycleLimit = 20 * numVectors + 100;

        #10 arstN = 1'b0;
        repeat (5) @(posedge Clk);
        arstN <= 1'b1;

        while (retired < numVectors && cycles < cycleLimit)
        begin
            @(posedge Clk);
            cycles++;
            // Values seen here are the ones the DUT acted on at this edge
            if (inCredit)
            begin
                creditPulses++;
                issueCredits++;
            end
            if (retValid)
            begin
                compareRetired();
            end
            if (issueCredits > 0 && issued < numVectors)
            begin
                inValid <= 1'b1;
                inInstr <= vecMem[4*issued + 1];
                issueCredits--;
                issued++;
            end
            else
            begin
                inValid <= 1'b0;
            end
            retCredit <= lfsr[0];
            lfsr = stepLfsr(lfsr);
        end

        if (retired < numVectors)
        begin
            $display("Timeout after %0d cycles with %0d of %0d results retired",
                     cycles, retired, numVectors);
            otherErrors++;
        end
        else
        begin
            inValid   <= 1'b0;
            retCredit <= 1'b0;
            // Last credit returns one cycle after its pop
            repeat (3)
            begin
                @(posedge Clk);
                if (inCredit)
                begin
                    creditPulses++;
                end
                if (retValid)
                begin
                    compareRetired();
                end
            end
            if (creditPulses != retired)
            begin
                $display("Issue credit pulses (%0d) do not match retired results (%0d)",
                         creditPulses, retired);
                otherErrors++;
            end
        end

        $display("Errors: %0d value mismatches, %0d other failures",
                 valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/sparcCore_vectors.txt ====
// First word is the vector count
// Columns: instruction word, expected rd, expected data, expected cc (NZVC)
00000015
821027FF 01 000007FF 0
05200000 02 80000000 0
86808002 03 00000000 7
88406001 04 00000801 7
8AA10001 05 00000002 0
8CE16003 06 FFFFFFFF 9
8E618000 07 FFFFFFFE 9
9089EF0F 08 00000F0E 0
92298001 09 FFFFF800 0
94300002 0A 7FFFFFFF 0
969A8002 0B FFFFFFFF 8
98BAE000 0C 00000000 4
9B286014 0D 7FF00000 4
9D38A004 0E F8000000 4
9F338004 0F 7C000000 4
80006005 00 00000000 4
A0803000 10 FFFFF000 8
A284000F 11 7BFFF000 1
01000000 00 00000000 1
A443000C 12 00000001 1
A6A0A001 13 7FFFFFFF 2

// ==== files.f ====
rtl/sparcPkg.sv
rtl/instrDecoder.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/retireBuffer.sv
rtl/sparcCore.sv
tests/sparcCore_asserts.sv
tests/sparcCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sparcCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module sparcCoreTb \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
